// ==== hdl/muldiv_pkg.sv ====
// ############################
// Multiply/divide unit package
// Operation encoding, signed mode and data width
// ############################

package muldiv_pkg;

  // Default data width of the unit
  parameter int XLEN = 32;

  // MUL gives the low word, MULH the high word,
  // DIV the quotient and REM the remainder
  typedef enum logic [1:0] {
    MD_OP_MUL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // Bit 0 marks operand A as signed, bit 1 marks operand B as signed
  typedef logic [1:0] md_signed_t;

  // True for the operations handled by the divider
  function automatic logic is_div_op(md_op_e op);
    logic result;
    result = (op == MD_OP_DIV) || (op == MD_OP_REM);
    return result;
  endfunction

endpackage

// ==== hdl/md_req_if.sv ====
// ############################
// Request link from the operand stage to the engines
// ############################

`timescale 1ns/1ns

interface md_req_if #(
  parameter int DataWidth = muldiv_pkg::XLEN
);

  logic                   valid;
  logic                   ready;
  muldiv_pkg::md_op_e     op;
  muldiv_pkg::md_signed_t signed_mode;
  logic [DataWidth-1:0]   op_a;
  logic [DataWidth-1:0]   op_b;

  modport source (
    output valid, op, signed_mode, op_a, op_b,
    input  ready
  );

  // Ready comes from the two engines and is combined at the top level
  modport engine (
    input valid, op, signed_mode, op_a, op_b
  );

endinterface

// ==== hdl/md_operand_stage.sv ====
// ############################
// Operand stage
// One-entry request register in front of the engines
// ############################

`timescale 1ns/1ns

module md_operand_stage #(
  parameter int DataWidth = 32
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  muldiv_pkg::md_op_e     op_i,
  input  muldiv_pkg::md_signed_t signed_mode_i,
  input  logic [DataWidth-1:0]   op_a_i,
  input  logic [DataWidth-1:0]   op_b_i,
  md_req_if.source               req
);

  logic                   valid_q;
  logic                   load;
  muldiv_pkg::md_op_e     op_q;
  muldiv_pkg::md_signed_t signed_mode_q;
  logic [DataWidth-1:0]   op_a_q;
  logic [DataWidth-1:0]   op_b_q;

  // Free when empty or when an engine takes the entry this cycle
  assign in_ready_o = !valid_q || req.ready;
  assign load       = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (req.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      op_q          <= op_i;
      signed_mode_q <= signed_mode_i;
      op_a_q        <= op_a_i;
      op_b_q        <= op_b_i;
    end
  end

  assign req.valid       = valid_q;
  assign req.op          = op_q;
  assign req.signed_mode = signed_mode_q;
  assign req.op_a        = op_a_q;
  assign req.op_b        = op_b_q;

endmodule

// ==== hdl/md_mult_fast.sv ====
// ############################
// Multiply engine
// Half-word multiply-accumulate over four steps, MUL and MULH
// ############################

`timescale 1ns/1ns

module md_mult_fast #(
  parameter int DataWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  md_req_if.engine             req,
  input  logic                 other_busy_i,
  output logic                 busy_o,
  output logic                 mult_ready_o,
  output logic                 mult_valid_o,
  input  logic                 mult_ready_i,
  output logic [DataWidth-1:0] mult_result_o
);

  localparam int HalfWidth = DataWidth / 2;
  localparam int AccWidth  = DataWidth + 2;

  typedef enum logic [1:0] {
    ALBL, ALBH, AHBL, AHBH
  } mult_state_e;

  mult_state_e            state_q, state_d;
  logic                   busy_q, busy_d;
  logic                   accept;
  logic [DataWidth-1:0]   a_q, b_q;
  logic                   mulh_q;
  muldiv_pkg::md_signed_t smode_q;
  logic [AccWidth-1:0]    acc_q, acc_d;
  logic [AccWidth-1:0]    accum;
  logic [AccWidth-1:0]    mac_res;
  logic [HalfWidth-1:0]   mult_op_a, mult_op_b;
  logic                   sign_a, sign_b;
  logic                   signed_mult;

  assign mult_ready_o = !busy_q && !muldiv_pkg::is_div_op(req.op) && !other_busy_i;
  assign accept       = req.valid && mult_ready_o;
  assign busy_o       = busy_q;
  assign signed_mult  = (smode_q != 2'b00);

  // Both factors carry one sign bit on top of the half word
  assign mac_res = $signed({sign_a, mult_op_a}) * $signed({sign_b, mult_op_b})
                   + $signed(accum);

  always_comb begin
    mult_op_a     = a_q[HalfWidth-1:0];
    mult_op_b     = b_q[HalfWidth-1:0];
    sign_a        = 1'b0;
    sign_b        = 1'b0;
    accum         = '0;
    acc_d         = mac_res;
    state_d       = state_q;
    busy_d        = busy_q;
    mult_valid_o  = 1'b0;
    mult_result_o = mac_res[DataWidth-1:0];
    if (accept) begin
      busy_d = 1'b1;
    end
    if (busy_q) begin
      unique case (state_q)
        ALBL: begin
          state_d = ALBH;
        end
        ALBH: begin
          mult_op_b = b_q[DataWidth-1:HalfWidth];
          sign_b    = smode_q[1] & b_q[DataWidth-1];
          accum     = {{(HalfWidth + 2){1'b0}}, acc_q[DataWidth-1:HalfWidth]};
          // MUL keeps only the low word, so the low half is parked here
          if (!mulh_q) begin
            acc_d = {2'b00, mac_res[HalfWidth-1:0], acc_q[HalfWidth-1:0]};
          end
          state_d = AHBL;
        end
        AHBL: begin
          mult_op_a = a_q[DataWidth-1:HalfWidth];
          sign_a    = smode_q[0] & a_q[DataWidth-1];
          if (!mulh_q) begin
            accum         = {{(HalfWidth + 2){1'b0}}, acc_q[DataWidth-1:HalfWidth]};
            mult_result_o = {mac_res[HalfWidth-1:0], acc_q[HalfWidth-1:0]};
            mult_valid_o  = 1'b1;
            if (mult_ready_i) begin
              busy_d  = 1'b0;
              state_d = ALBL;
            end
          end else begin
            accum   = acc_q;
            state_d = AHBH;
          end
        end
        AHBH: begin
          mult_op_a     = a_q[DataWidth-1:HalfWidth];
          mult_op_b     = b_q[DataWidth-1:HalfWidth];
          sign_a        = smode_q[0] & a_q[DataWidth-1];
          sign_b        = smode_q[1] & b_q[DataWidth-1];
          // Middle sum shifted down by a half word, sign kept when any operand is signed
          accum         = {{HalfWidth{signed_mult & acc_q[AccWidth-1]}},
                           acc_q[AccWidth-1:HalfWidth]};
          mult_valid_o  = 1'b1;
          if (mult_ready_i) begin
            busy_d  = 1'b0;
            state_d = ALBL;
          end
        end
        default: begin
          state_d = ALBL;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      state_q <= ALBL;
    end else begin
      busy_q  <= busy_d;
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      a_q     <= req.op_a;
      b_q     <= req.op_b;
      mulh_q  <= (req.op == muldiv_pkg::MD_OP_MULH);
      smode_q <= req.signed_mode;
    end
    // Accumulator is frozen while a result waits
    if (busy_q && !mult_valid_o) begin
      acc_q <= acc_d;
    end
  end

endmodule

// ==== hdl/md_div_long.sv ====
// ############################
// Divide engine
// Restoring long division with abs and sign fix-up, DIV and REM
// ############################

`timescale 1ns/1ns

module md_div_long #(
  parameter int DataWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  md_req_if.engine             req,
  input  logic                 other_busy_i,
  output logic                 busy_o,
  output logic                 div_ready_o,
  output logic                 div_valid_o,
  input  logic                 div_ready_i,
  output logic [DataWidth-1:0] div_result_o
);

  localparam int CntWidth = $clog2(DataWidth);

  typedef enum logic [2:0] {
    IDLE, ABS_A, ABS_B, COMP, LAST, CHANGE_SIGN, FINISH
  } div_state_e;

  div_state_e           state_q, state_d;
  logic [CntWidth-1:0]  cnt_q, cnt_d, cnt_dec;
  logic                 accept;
  logic [DataWidth-1:0] num_q, den_q, quot_q;
  logic [DataWidth:0]   rem_q;
  logic                 sign_a_q, sign_b_q, is_rem_q;
  logic [DataWidth+1:0] sub_a, sub_b, sub_res;
  logic                 ge;
  logic [DataWidth-1:0] next_rem, next_quot, one_shift;

  assign div_ready_o = (state_q == IDLE) && muldiv_pkg::is_div_op(req.op) && !other_busy_i;
  assign accept      = req.valid && div_ready_o;
  assign busy_o      = (state_q != IDLE);

  // Single subtractor, used for negation and for the remainder compare
  always_comb begin
    sub_a = '0;
    sub_b = {2'b00, num_q};
    unique case (state_q)
      ABS_B: sub_b = {2'b00, den_q};
      COMP, LAST: begin
        sub_a = {1'b0, rem_q};
        sub_b = {2'b00, den_q};
      end
      CHANGE_SIGN: sub_b = {2'b00, quot_q};
      default: sub_a = '0;
    endcase
  end

  assign sub_res   = sub_a - sub_b;
  assign ge        = ~sub_res[DataWidth+1];
  assign next_rem  = ge ? sub_res[DataWidth-1:0] : rem_q[DataWidth-1:0];
  assign one_shift = {{(DataWidth - 1){1'b0}}, 1'b1} << cnt_q;
  assign next_quot = ge ? (quot_q | one_shift) : quot_q;
  assign cnt_dec   = cnt_q - 1'b1;

  always_comb begin
    state_d     = state_q;
    cnt_d       = cnt_q;
    div_valid_o = 1'b0;
    unique case (state_q)
      IDLE: begin
        // Zero divisor skips straight to the result
        if (accept) begin
          state_d = (req.op_b == '0) ? FINISH : ABS_A;
        end
      end
      ABS_A: state_d = ABS_B;
      ABS_B: begin
        state_d = COMP;
        cnt_d   = CntWidth'(DataWidth - 1);
      end
      COMP: begin
        cnt_d = cnt_dec;
        if (cnt_q == CntWidth'(1)) begin
          state_d = LAST;
        end
      end
      LAST:        state_d = CHANGE_SIGN;
      CHANGE_SIGN: state_d = FINISH;
      FINISH: begin
        div_valid_o = 1'b1;
        if (div_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    unique case (state_q)
      IDLE: begin
        if (accept) begin
          num_q    <= req.op_a;
          den_q    <= req.op_b;
          sign_a_q <= req.signed_mode[0] & req.op_a[DataWidth-1];
          sign_b_q <= req.signed_mode[1] & req.op_b[DataWidth-1];
          is_rem_q <= (req.op == muldiv_pkg::MD_OP_REM);
          // Divide-by-zero result, replaced later on a normal run
          quot_q   <= (req.op == muldiv_pkg::MD_OP_REM) ? req.op_a : '1;
        end
      end
      ABS_A: begin
        if (sign_a_q) begin
          num_q <= sub_res[DataWidth-1:0];
        end
      end
      ABS_B: begin
        if (sign_b_q) begin
          den_q <= sub_res[DataWidth-1:0];
        end
        rem_q  <= {{DataWidth{1'b0}}, num_q[DataWidth-1]};
        quot_q <= '0;
      end
      COMP: begin
        rem_q  <= {next_rem, num_q[cnt_dec]};
        quot_q <= next_quot;
      end
      LAST: quot_q <= is_rem_q ? next_rem : next_quot;
      CHANGE_SIGN: begin
        // Remainder follows A, quotient flips when the signs differ
        if (is_rem_q ? sign_a_q : (sign_a_q ^ sign_b_q)) begin
          quot_q <= sub_res[DataWidth-1:0];
        end
      end
      default: begin
      end
    endcase
  end

  assign div_result_o = quot_q;

endmodule

// ==== hdl/md_result_stage.sv ====
// ############################
// Result stage
// One-entry output register fed by either engine
// ############################

`timescale 1ns/1ns

module md_result_stage #(
  parameter int DataWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 mult_valid_i,
  output logic                 mult_ready_o,
  input  logic [DataWidth-1:0] mult_result_i,
  input  logic                 div_valid_i,
  output logic                 div_ready_o,
  input  logic [DataWidth-1:0] div_result_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [DataWidth-1:0] result_o
);

  logic                 valid_q;
  logic [DataWidth-1:0] result_q;
  logic                 can_take;
  logic                 take_mult, take_div;

  // Refill allowed in the same cycle the old result drains
  assign can_take     = !valid_q || out_ready_i;
  assign mult_ready_o = can_take;
  assign div_ready_o  = can_take;
  assign take_mult    = mult_valid_i && can_take;
  assign take_div     = div_valid_i && can_take;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (take_mult || take_div) begin
      valid_q <= 1'b1;
    end else if (out_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Only one engine presents at a time
  always_ff @(posedge clk_i) begin
    if (take_div) begin
      result_q <= div_result_i;
    end else if (take_mult) begin
      result_q <= mult_result_i;
    end
  end

  assign out_valid_o = valid_q;
  assign result_o    = result_q;

endmodule

// ==== hdl/muldiv_top.sv ====
// ############################
// Multi-cycle multiply/divide unit
// Operand stage, two engines and result stage
// ############################

`timescale 1ns/1ns

module muldiv_top #(
  parameter int DataWidth = muldiv_pkg::XLEN
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  muldiv_pkg::md_op_e     op_i,
  input  muldiv_pkg::md_signed_t signed_mode_i,
  input  logic [DataWidth-1:0]   op_a_i,
  input  logic [DataWidth-1:0]   op_b_i,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output logic [DataWidth-1:0]   result_o
);

  logic                 mult_busy, div_busy;
  logic                 mult_req_ready, div_req_ready;
  logic                 mult_valid, mult_ready;
  logic                 div_valid, div_ready;
  logic [DataWidth-1:0] mult_result, div_result;

  md_req_if #(.DataWidth(DataWidth)) req_if ();

  // The request is taken by whichever engine owns the operation
  assign req_if.ready = mult_req_ready | div_req_ready;

  md_operand_stage #(.DataWidth(DataWidth)) i_operand_stage (
    .clk_i, .rst_ni, .in_valid_i, .in_ready_o, .op_i, .signed_mode_i, .op_a_i, .op_b_i,
    .req (req_if.source)
  );

  md_mult_fast #(.DataWidth(DataWidth)) i_mult (
    .clk_i, .rst_ni,
    .req           (req_if.engine),
    .other_busy_i  (div_busy),
    .busy_o        (mult_busy),
    .mult_ready_o  (mult_req_ready),
    .mult_valid_o  (mult_valid),
    .mult_ready_i  (mult_ready),
    .mult_result_o (mult_result)
  );

  md_div_long #(.DataWidth(DataWidth)) i_div (
    .clk_i, .rst_ni,
    .req          (req_if.engine),
    .other_busy_i (mult_busy),
    .busy_o       (div_busy),
    .div_ready_o  (div_req_ready),
    .div_valid_o  (div_valid),
    .div_ready_i  (div_ready),
    .div_result_o (div_result)
  );

  md_result_stage #(.DataWidth(DataWidth)) i_result_stage (
    .clk_i, .rst_ni,
    .mult_valid_i  (mult_valid),
    .mult_ready_o  (mult_ready),
    .mult_result_i (mult_result),
    .div_valid_i   (div_valid),
    .div_ready_o   (div_ready),
    .div_result_i  (div_result),
    .out_valid_o, .out_ready_i, .result_o
  );

endmodule

// ==== tests/tb_muldiv.sv ====
// ##############################
// Testbench for the multiply/divide unit
// Directed and random requests checked against a 64-bit model
// ##############################

`timescale 1ns/1ns

module tb_muldiv;

  localparam int NumRandom   = 200;
  localparam int NumDirected = 142;
  localparam int NumOps      = NumDirected + 2 * NumRandom;
  localparam int CyclesPerOp = 40;
  localparam int ResetCycles = 3;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   in_valid_i;
  logic                   in_ready_o;
  muldiv_pkg::md_op_e     op_i;
  muldiv_pkg::md_signed_t signed_mode_i;
  logic [31:0]            op_a_i;
  logic [31:0]            op_b_i;
  logic                   out_valid_o;
  logic                   out_ready_i;
  logic [31:0]            result_o;

  integer                 seed;
  logic [31:0]            ready_rnd;
  logic                   toggle_ready;
  logic                   hold_active;
  logic [31:0]            held_value;
  logic [31:0]            exp_val;
  string                  exp_desc;
  int                     n_sent;
  int                     n_done;
  logic [31:0]            exp_q[$];
  string                  desc_q[$];
  muldiv_pkg::md_op_e     rnd_op[NumRandom];
  muldiv_pkg::md_signed_t rnd_mode[NumRandom];
  logic [31:0]            rnd_a[NumRandom];
  logic [31:0]            rnd_b[NumRandom];
  logic [31:0]            corner[5];

  muldiv_top #(.DataWidth(32)) i_dut (
    .clk_i, .rst_ni, .in_valid_i, .in_ready_o, .op_i, .signed_mode_i, .op_a_i, .op_b_i,
    .out_valid_o, .out_ready_i, .result_o
  );

  always #50 clk_i = ~clk_i;

  // Expected value from sign-extended 64-bit arithmetic
  task automatic compute_expected(input muldiv_pkg::md_op_e op,
                                  input muldiv_pkg::md_signed_t mode,
                                  input logic [31:0] a, input logic [31:0] b,
                                  output logic [31:0] expected);
    longint ext_a;
    longint ext_b;
    longint res;
    ext_a = mode[0] ? longint'($signed(a)) : longint'(a);
    ext_b = mode[1] ? longint'($signed(b)) : longint'(b);
    if (muldiv_pkg::is_div_op(op)) begin
      if (b == 32'd0) begin
        res = (op == muldiv_pkg::MD_OP_DIV) ? 64'hffff_ffff_ffff_ffff : ext_a;
      end else if (mode == 2'b11 && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
        // Most negative over -1 wraps with a remainder of 0
        res = (op == muldiv_pkg::MD_OP_DIV) ? 64'h8000_0000 : 64'd0;
      end else if (op == muldiv_pkg::MD_OP_DIV) begin
        res = ext_a / ext_b;
      end else begin
        res = ext_a % ext_b;
      end
      expected = res[31:0];
    end else begin
      res      = ext_a * ext_b;
      expected = (op == muldiv_pkg::MD_OP_MULH) ? res[63:32] : res[31:0];
    end
  endtask

  task automatic check_result(input logic [31:0] got, input logic [31:0] expected,
                              input string what);
    if (got !== expected) begin
      $display("error: %0t ns: %s: got %h, expected %h", $time, what, got, expected);
      $display("*** FAILED ***");
      $fatal(1, "result mismatch");
    end
  endtask

  // Drives one request and returns on the edge where it is taken
  task automatic send_request(input muldiv_pkg::md_op_e op, input muldiv_pkg::md_signed_t mode,
                              input logic [31:0] a, input logic [31:0] b);
    logic [31:0] expected;
    compute_expected(op, mode, a, b, expected);
    exp_q.push_back(expected);
    desc_q.push_back($sformatf("%s mode %b a %h b %h", op.name(), mode, a, b));
    n_sent++;
    in_valid_i    <= 1'b1;
    op_i          <= op;
    signed_mode_i <= mode;
    op_a_i        <= a;
    op_b_i        <= b;
    @(posedge clk_i);
    while (!in_ready_o) @(posedge clk_i);
  endtask

  task automatic drain_results();
    in_valid_i <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk_i);
  endtask

  task automatic idle_after_reset();
    check_result({31'b0, out_valid_o}, 32'd0, "out_valid after reset");
    check_result({31'b0, in_ready_o}, 32'd1, "in_ready after reset");
  endtask

  task automatic mul_corner_cases();
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 5; j++) begin
        send_request(muldiv_pkg::MD_OP_MUL, 2'b11, corner[i], corner[j]);
        send_request(muldiv_pkg::MD_OP_MULH, 2'b11, corner[i], corner[j]);
        send_request(muldiv_pkg::MD_OP_MULH, 2'b01, corner[i], corner[j]);
        send_request(muldiv_pkg::MD_OP_MULH, 2'b00, corner[i], corner[j]);
      end
    end
    drain_results();
  endtask

  task automatic div_sign_cases();
    logic [31:0] div_a[8];
    logic [31:0] div_b[8];
    div_a = '{32'd100, 32'hffff_ff9c, 32'd100, 32'hffff_ff9c,
              32'd7, 32'h8000_0000, 32'hffff_ffff, 32'h1234_5678};
    div_b = '{32'd7, 32'd7, 32'hffff_fff9, 32'hffff_fff9,
              32'd100, 32'd3, 32'd2, 32'd1};
    for (int i = 0; i < 8; i++) begin
      send_request(muldiv_pkg::MD_OP_DIV, 2'b11, div_a[i], div_b[i]);
      send_request(muldiv_pkg::MD_OP_REM, 2'b11, div_a[i], div_b[i]);
      send_request(muldiv_pkg::MD_OP_DIV, 2'b00, div_a[i], div_b[i]);
      send_request(muldiv_pkg::MD_OP_REM, 2'b00, div_a[i], div_b[i]);
    end
    drain_results();
  endtask

  task automatic div_special_cases();
    for (int m = 0; m < 2; m++) begin
      send_request(muldiv_pkg::MD_OP_DIV, m[0] ? 2'b11 : 2'b00, 32'hffff_fffb, 32'd0);
      send_request(muldiv_pkg::MD_OP_REM, m[0] ? 2'b11 : 2'b00, 32'hffff_fffb, 32'd0);
      send_request(muldiv_pkg::MD_OP_DIV, m[0] ? 2'b11 : 2'b00, 32'h0001_2345, 32'd0);
      send_request(muldiv_pkg::MD_OP_REM, m[0] ? 2'b11 : 2'b00, 32'h0001_2345, 32'd0);
    end
    send_request(muldiv_pkg::MD_OP_DIV, 2'b11, 32'h8000_0000, 32'hffff_ffff);
    send_request(muldiv_pkg::MD_OP_REM, 2'b11, 32'h8000_0000, 32'hffff_ffff);
    drain_results();
  endtask

  // Mixed operations with some zero and small divisors
  task automatic build_random_stream();
    logic [31:0] ctl;
    for (int i = 0; i < NumRandom; i++) begin
      ctl         = $random(seed);
      rnd_op[i]   = muldiv_pkg::md_op_e'(ctl[1:0]);
      rnd_mode[i] = (ctl[3:2] == 2'b10) ? 2'b11 : ctl[3:2];
      rnd_a[i]    = $random(seed);
      if (ctl[6:4] == 3'd0) begin
        rnd_b[i] = 32'd0;
      end else if (ctl[6:4] == 3'd1) begin
        rnd_b[i] = {24'd0, ctl[15:8]};
      end else begin
        rnd_b[i] = $random(seed);
      end
    end
  endtask

  task automatic replay_random_stream(input logic backpressure);
    if (backpressure) begin
      toggle_ready <= 1'b1;
    end
    for (int i = 0; i < NumRandom; i++) begin
      send_request(rnd_op[i], rnd_mode[i], rnd_a[i], rnd_b[i]);
    end
    drain_results();
    toggle_ready <= 1'b0;
    @(posedge clk_i);
    out_ready_i <= 1'b1;
  endtask

  always @(posedge clk_i) begin
    if (toggle_ready) begin
      ready_rnd = $random(seed);
      out_ready_i <= ready_rnd[0];
    end
  end

  // Output monitor that pops the expected queue in request order
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (hold_active) begin
        check_result({31'b0, out_valid_o}, 32'd1, "out_valid kept until accepted");
        check_result(result_o, held_value, "result kept until accepted");
      end
      hold_active = 1'b0;
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected result %h at %0t ns with no request outstanding",
                   result_o, $time);
          $display("*** FAILED ***");
          $fatal(1, "extra result");
        end else begin
          exp_val  = exp_q.pop_front();
          exp_desc = desc_q.pop_front();
          check_result(result_o, exp_val, exp_desc);
          n_done++;
        end
      end else if (out_valid_o) begin
        hold_active = 1'b1;
        held_value  = result_o;
      end
    end
  end

  initial begin
    repeat (NumOps * CyclesPerOp + ResetCycles + 10) @(posedge clk_i);
    $display("Timeout: the unit stopped answering, %0d of %0d results received",
             n_done, n_sent);
    $display("*** FAILED ***");
    $fatal(1, "timeout");
  end

  initial begin
    seed          = 32'he297_9cf9;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    in_valid_i    = 1'b0;
    op_i          = muldiv_pkg::MD_OP_MUL;
    signed_mode_i = 2'b00;
    op_a_i        = 32'd0;
    op_b_i        = 32'd0;
    out_ready_i   = 1'b1;
    toggle_ready  = 1'b0;
    hold_active   = 1'b0;
    n_sent        = 0;
    n_done        = 0;
    corner        = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    idle_after_reset();
    mul_corner_cases();
    div_sign_cases();
    div_special_cases();
    build_random_stream();
    replay_random_stream(1'b0);
    replay_random_stream(1'b1);
    // Every request is answered, so no further result may be waiting
    if (!out_valid_o) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("Stray result %h still offered after all %0d requests were answered",
               result_o, n_sent);
      $display("*** FAILED ***");
      $fatal(1, "stray result");
    end
  end

endmodule

// ==== muldiv.f ====
hdl/muldiv_pkg.sv
hdl/md_req_if.sv
hdl/md_operand_stage.sv
hdl/md_mult_fast.sv
hdl/md_div_long.sv
hdl/md_result_stage.sv
hdl/muldiv_top.sv
tests/tb_muldiv.sv

// ==== Makefile ====
# Verilator build and run of the muldiv testbench

VERILATOR ?= verilator
TOP       ?= tb_muldiv
FILELIST  ?= muldiv.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
